// File: build.f
src/fir_pkg.sv
src/fir_phase_seq.sv
src/fir_sample_line.sv
src/fir_coef_bank.sv
src/fir_cmac.sv
src/fir_top.sv
verification/tb_fir_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the FIR filter simulation with Verilator

cd "$(dirname "$0")"
status=$?
if [ $status -ne 0 ]; then
  echo "cannot enter the project directory"
  exit $status
fi

verilator --binary --timing -f build.f --top-module tb_fir_top \
  -Mdir obj_dir -o sim_fir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed"
  exit $status
fi

./obj_dir/sim_fir
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi

exit 0

// File: src/fir_cmac.sv
// FIR complex multiply-accumulate
`timescale 1ns/1ps

module fir_cmac #(
  parameter int OUT_SHIFT_P = fir_pkg::OUT_SHIFT
) (
  input  logic                                          clk,
  input  logic                                          RST,
  input  fir_pkg::phase_e                               op_phase_i,
  input  fir_pkg::cplx_preadd_t [fir_pkg::NUM_LANES-1:0] samp_i,
  input  fir_pkg::cplx_coef_t   [fir_pkg::NUM_LANES-1:0] coef_i,
  output logic                                          valid_o,
  output fir_pkg::cplx_result_t                         result_o
);

  import fir_pkg::*;

  // Real products, named coefficient part then sample part
  prod_t  prod_ii [NUM_LANES];
  prod_t  prod_qq [NUM_LANES];
  prod_t  prod_qi [NUM_LANES];
  prod_t  prod_iq [NUM_LANES];
  phase_e prod_phase_q;

  acc_t   sum_i;
  acc_t   sum_q;
  acc_t   acc_i_q;
  acc_t   acc_q_q;
  acc_t   total_i;
  acc_t   total_q;
  acc_t   scaled_i;
  acc_t   scaled_q;

  ////////////////////////////////////////////////////////////
  // Multiplier stage
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    for (int l = 0; l < NUM_LANES; l++)
    begin
      prod_ii[l] <= prod_t'(coef_i[l].i) * prod_t'(samp_i[l].i);
      prod_qq[l] <= prod_t'(coef_i[l].q) * prod_t'(samp_i[l].q);
      prod_qi[l] <= prod_t'(coef_i[l].q) * prod_t'(samp_i[l].i);
      prod_iq[l] <= prod_t'(coef_i[l].i) * prod_t'(samp_i[l].q);
    end
  end

  // Phase tag travels with the products
  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
      prod_phase_q <= PH_IDLE;
    else
      prod_phase_q <= op_phase_i;
  end

  // Complex products summed over the lanes
  always_comb
  begin
    sum_i = '0;
    sum_q = '0;
    for (int l = 0; l < NUM_LANES; l++)
    begin
      sum_i = sum_i + acc_t'(prod_ii[l]) - acc_t'(prod_qq[l]);
      sum_q = sum_q + acc_t'(prod_qi[l]) + acc_t'(prod_iq[l]);
    end
  end

  assign total_i  = acc_i_q + sum_i;
  assign total_q  = acc_q_q + sum_q;
  assign scaled_i = total_i >>> OUT_SHIFT_P;
  assign scaled_q = total_q >>> OUT_SHIFT_P;

  ////////////////////////////////////////////////////////////
  // Accumulator and output register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    case (prod_phase_q)
      PH_0:
      begin
        acc_i_q <= sum_i;
        acc_q_q <= sum_q;
      end
      PH_1:
      begin
        acc_i_q <= total_i;
        acc_q_q <= total_q;
      end
      default:
      begin
        acc_i_q <= acc_i_q;
        acc_q_q <= acc_q_q;
      end
    endcase
  end

  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      valid_o  <= 1'b0;
      result_o <= '0;
    end
    else
    begin
      valid_o <= (prod_phase_q == PH_2);
      if (prod_phase_q == PH_2)
      begin
        // Plain truncation to the output width
        result_o.i <= scaled_i[$bits(result_t)-1:0];
        result_o.q <= scaled_q[$bits(result_t)-1:0];
      end
    end
  end

endmodule

// File: src/fir_coef_bank.sv
// FIR coefficient memory
`timescale 1ns/1ps

module fir_coef_bank (
  input  logic                                         clk,
  input  logic                                         RST,
  input  logic                                         we_i,
  input  fir_pkg::coef_addr_t                          addr_i,
  input  fir_pkg::cplx_coef_t                          coef_i,
  input  fir_pkg::phase_e                              phase_i,
  output fir_pkg::cplx_coef_t [fir_pkg::NUM_LANES-1:0] lanes_o
);

  import fir_pkg::*;

  localparam int COEF_IDX_W = $clog2(COEF_DEPTH);

  cplx_coef_t mem_q [COEF_DEPTH];
  int         base;

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      for (int a = 0; a < COEF_DEPTH; a++)
        mem_q[a] <= '0;
    end
    // Addresses past the table are dropped
    else if (we_i && (addr_i < COEF_ADDR_W'(COEF_DEPTH)))
      mem_q[addr_i[COEF_IDX_W-1:0]] <= coef_i;
  end

  assign base = phase_base(phase_i);

  // Five coefficients per phase, entry 15 never read
  always_ff @(posedge clk)
  begin
    if (phase_i != PH_IDLE)
    begin
      for (int l = 0; l < NUM_LANES; l++)
        lanes_o[l] <= mem_q[COEF_IDX_W'(base + l)];
    end
  end

endmodule

// File: src/fir_phase_seq.sv
// FIR phase sequencer
`timescale 1ns/1ps

module fir_phase_seq (
  input  logic            clk,
  input  logic            RST,
  input  logic            push_i,
  output logic            shift_o,
  output fir_pkg::phase_e phase_o,
  output fir_pkg::phase_e op_phase_o
);

  import fir_pkg::*;

  phase_e phase_q;
  phase_e phase_d;
  phase_e op_phase_q;
  logic   accept;

  // A new sample fits only once the previous one reached its last phase
  assign accept  = push_i && ((phase_q == PH_IDLE) || (phase_q == PH_2));
  assign shift_o = accept;

  always_comb
  begin
    if (accept)
      phase_d = PH_0;
    else
    begin
      case (phase_q)
        PH_0:    phase_d = PH_1;
        PH_1:    phase_d = PH_2;
        default: phase_d = PH_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // State and operand tag
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      phase_q    <= PH_IDLE;
      op_phase_q <= PH_IDLE;
    end
    else
    begin
      phase_q <= phase_d;
      // Follows the operand registers by one edge
      op_phase_q <= phase_q;
    end
  end

  assign phase_o    = phase_q;
  assign op_phase_o = op_phase_q;

endmodule

// File: src/fir_pkg.sv
// FIR filter shared definitions
package fir_pkg;

  ////////////////////////////////////////////////////////////
  // Filter geometry
  ////////////////////////////////////////////////////////////
  localparam int NUM_TAPS    = 29;
  localparam int NUM_UNIQUE  = 15;
  localparam int NUM_LANES   = 5;
  localparam int NUM_PHASES  = 3;
  localparam int COEF_DEPTH  = 16;
  localparam int COEF_ADDR_W = 5;

  // Accumulator to output scaling
  localparam int OUT_SHIFT = 23;

  ////////////////////////////////////////////////////////////
  // Scalar types
  ////////////////////////////////////////////////////////////
  typedef logic signed [23:0] sample_t;
  typedef logic signed [26:0] coef_t;
  typedef logic signed [24:0] preadd_t;
  typedef logic signed [51:0] prod_t;
  typedef logic signed [55:0] acc_t;
  typedef logic signed [31:0] result_t;
  typedef logic [COEF_ADDR_W-1:0] coef_addr_t;

  // Complex pairs, real part in the upper half
  typedef struct packed {
    sample_t i;
    sample_t q;
  } cplx_sample_t;

  typedef struct packed {
    coef_t i;
    coef_t q;
  } cplx_coef_t;

  typedef struct packed {
    preadd_t i;
    preadd_t q;
  } cplx_preadd_t;

  typedef struct packed {
    result_t i;
    result_t q;
  } cplx_result_t;

  // Sequencer state, one cycle per phase
  typedef enum logic [1:0] {
    PH_IDLE = 2'd0,
    PH_0    = 2'd1,
    PH_1    = 2'd2,
    PH_2    = 2'd3
  } phase_e;

  // First coefficient index handled in a phase
  function automatic int phase_base(phase_e ph);
    case (ph)
      PH_1:    return NUM_LANES;
      PH_2:    return 2 * NUM_LANES;
      default: return 0;
    endcase
  endfunction

endpackage

// File: src/fir_sample_line.sv
// FIR sample delay line with pre-adders
`timescale 1ns/1ps

module fir_sample_line (
  input  logic                                           clk,
  input  logic                                           RST,
  input  logic                                           shift_i,
  input  fir_pkg::cplx_sample_t                          sample_i,
  input  fir_pkg::phase_e                                phase_i,
  output fir_pkg::cplx_preadd_t [fir_pkg::NUM_LANES-1:0] lanes_o
);

  import fir_pkg::*;

  localparam int TAP_IDX_W = $clog2(NUM_TAPS);

  // Index 0 holds the newest sample x[n]
  cplx_sample_t [NUM_TAPS-1:0]  taps_q;
  cplx_preadd_t [NUM_LANES-1:0] lanes_d;
  int                           base;

  ////////////////////////////////////////////////////////////
  // Delay line
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
      taps_q <= '0;
    else if (shift_i)
      taps_q <= {taps_q[NUM_TAPS-2:0], sample_i};
  end

  assign base = phase_base(phase_i);

  ////////////////////////////////////////////////////////////
  // Symmetric pre-add
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    logic [TAP_IDX_W-1:0] k;
    logic [TAP_IDX_W-1:0] k_mirror;
    cplx_sample_t         near_s;
    cplx_sample_t         far_s;

    for (int l = 0; l < NUM_LANES; l++)
    begin
      k        = TAP_IDX_W'(base + l);
      k_mirror = TAP_IDX_W'(NUM_TAPS - 1) - k;
      near_s   = taps_q[k];
      // Centre tap x[n-14] has no partner
      if (k == TAP_IDX_W'(NUM_UNIQUE - 1))
        far_s = '0;
      else
        far_s = taps_q[k_mirror];
      lanes_d[l].i = preadd_t'(near_s.i) + preadd_t'(far_s.i);
      lanes_d[l].q = preadd_t'(near_s.q) + preadd_t'(far_s.q);
    end
  end

  // Operands for the multipliers, one edge after the phase
  always_ff @(posedge clk)
  begin
    if (phase_i != PH_IDLE)
      lanes_o <= lanes_d;
  end

endmodule

// File: src/fir_top.sv
// Symmetric complex FIR filter top
`timescale 1ns/1ps

module fir_top #(
  parameter int OUT_SHIFT_P = fir_pkg::OUT_SHIFT
) (
  input  logic                  clk,
  input  logic                  RST,
  input  logic                  push_i,
  input  fir_pkg::cplx_sample_t sample_i,
  input  logic                  coef_we_i,
  input  fir_pkg::coef_addr_t   coef_addr_i,
  input  fir_pkg::cplx_coef_t   coef_i,
  output logic                  valid_o,
  output fir_pkg::cplx_result_t result_o
);

  import fir_pkg::*;

  logic                         shift_w;
  phase_e                       phase_w;
  phase_e                       op_phase_w;
  cplx_preadd_t [NUM_LANES-1:0] samp_lanes_w;
  cplx_coef_t   [NUM_LANES-1:0] coef_lanes_w;

  // Push acceptance and phase stepping
  fir_phase_seq i_phase_seq (
    .clk        (clk),
    .RST        (RST),
    .push_i     (push_i),
    .shift_o    (shift_w),
    .phase_o    (phase_w),
    .op_phase_o (op_phase_w)
  );

  ////////////////////////////////////////////////////////////
  // Operand paths
  ////////////////////////////////////////////////////////////
  fir_sample_line i_sample_line (
    .clk      (clk),
    .RST      (RST),
    .shift_i  (shift_w),
    .sample_i (sample_i),
    .phase_i  (phase_w),
    .lanes_o  (samp_lanes_w)
  );

  fir_coef_bank i_coef_bank (
    .clk     (clk),
    .RST     (RST),
    .we_i    (coef_we_i),
    .addr_i  (coef_addr_i),
    .coef_i  (coef_i),
    .phase_i (phase_w),
    .lanes_o (coef_lanes_w)
  );

  fir_cmac #(
    .OUT_SHIFT_P (OUT_SHIFT_P)
  ) i_cmac (
    .clk        (clk),
    .RST        (RST),
    .op_phase_i (op_phase_w),
    .samp_i     (samp_lanes_w),
    .coef_i     (coef_lanes_w),
    .valid_o    (valid_o),
    .result_o   (result_o)
  );

endmodule

// File: verification/tb_fir_top.sv
// Complex FIR filter testbench
`timescale 1ns/1ps

module tb_fir_top;

  import fir_pkg::*;

  localparam int RESET_CYCLES  = 16;
  localparam int IDLE_CYCLES   = 20;
  localparam int LOAD_CYCLES   = NUM_UNIQUE + 1;
  localparam int RAND_PUSHES   = 40;
  localparam int RELOAD_PUSHES = 30;
  localparam int DROP_ROUNDS   = 6;
  localparam int IRREG_PUSHES  = 30;
  localparam int LATENCY       = 5;
  // Twice the full-rate pushes, widest irregular gaps and drains
  localparam int MAX_CYCLES = 2 * (RESET_CYCLES + IDLE_CYCLES + 3 * LOAD_CYCLES
    + NUM_PHASES * (NUM_TAPS + RAND_PUSHES + RELOAD_PUSHES + 3 * DROP_ROUNDS)
    + 6 * IRREG_PUSHES + 6 * (LATENCY + 2));

  logic         clk = 1'b0;
  logic         RST;
  logic         push_i;
  cplx_sample_t sample_i;
  logic         coef_we_i;
  coef_addr_t   coef_addr_i;
  cplx_coef_t   coef_i;
  logic         valid_o;
  cplx_result_t result_o;

  // Reference model state with hist[0] as the newest sample
  cplx_sample_t hist [NUM_TAPS];
  cplx_coef_t   coefs [NUM_UNIQUE];
  cplx_result_t exp_q [$];
  int           due_q [$];
  cplx_result_t last_exp;
  int           last_accept;
  int           cycle_cnt = 0;

  fir_top i_dut (
    .clk         (clk),
    .RST         (RST),
    .push_i      (push_i),
    .sample_i    (sample_i),
    .coef_we_i   (coef_we_i),
    .coef_addr_i (coef_addr_i),
    .coef_i      (coef_i),
    .valid_o     (valid_o),
    .result_o    (result_o)
  );

  always #50 clk = ~clk;

  task automatic compare(input string name, input logic signed [63:0] act,
                         input logic signed [63:0] exp);
    if (act !== exp)
    begin
      $display("error at %0t: %s is %0d, expected %0d", $time, name, act, exp);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  function automatic cplx_result_t model_output();
    longint       acc_i;
    longint       acc_q;
    longint       di;
    longint       dq;
    cplx_result_t r;
    acc_i = 0;
    acc_q = 0;
    for (int k = 0; k < NUM_UNIQUE; k++)
    begin
      di = longint'(hist[k].i);
      dq = longint'(hist[k].q);
      // Centre tap is its own mirror
      if (k != NUM_TAPS - 1 - k)
      begin
        di += longint'(hist[NUM_TAPS-1-k].i);
        dq += longint'(hist[NUM_TAPS-1-k].q);
      end
      acc_i += longint'(coefs[k].i) * di - longint'(coefs[k].q) * dq;
      acc_q += longint'(coefs[k].q) * di + longint'(coefs[k].i) * dq;
    end
    r.i = result_t'(acc_i >>> OUT_SHIFT);
    r.q = result_t'(acc_q >>> OUT_SHIFT);
    return r;
  endfunction

  function automatic cplx_sample_t rand_sample();
    cplx_sample_t s;
    s.i = sample_t'($urandom());
    s.q = sample_t'($urandom());
    return s;
  endfunction

  function automatic cplx_coef_t rand_coef();
    cplx_coef_t c;
    c.i = coef_t'($urandom());
    c.q = coef_t'($urandom());
    return c;
  endfunction

  // Output monitor sampling due counts at the negedge after the accept edge
  always @(negedge clk)
  begin
    logic exp_valid;
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("timeout: the run reached %0d cycles without finishing", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
    else
    begin
      exp_valid = 1'b0;
      if (due_q.size() > 0)
        exp_valid = (due_q[0] == cycle_cnt);
      compare("valid_o", 64'(valid_o), 64'(exp_valid));
      if (exp_valid)
      begin
        compare("result_o.i", 64'(result_o.i), 64'(exp_q[0].i));
        compare("result_o.q", 64'(result_o.q), 64'(exp_q[0].q));
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////
  task automatic push_sample(input cplx_sample_t s, input int gap);
    int accept_at;
    @(posedge clk);
    push_i   <= 1'b1;
    sample_i <= s;
    accept_at = cycle_cnt + 2;
    // A new sample fits once three edges passed since the last accept
    if (accept_at - last_accept >= NUM_PHASES)
    begin
      last_accept = accept_at;
      for (int t = NUM_TAPS - 1; t > 0; t--)
        hist[t] = hist[t-1];
      hist[0] = s;
      last_exp = model_output();
      exp_q.push_back(last_exp);
      due_q.push_back(accept_at + LATENCY);
    end
    repeat (gap - 1)
    begin
      @(posedge clk);
      push_i <= 1'b0;
    end
  endtask

  task automatic load_coefs();
    cplx_coef_t c;
    for (int k = 0; k < NUM_UNIQUE; k++)
    begin
      c = rand_coef();
      coefs[k] = c;
      @(posedge clk);
      coef_we_i   <= 1'b1;
      coef_addr_i <= coef_addr_t'(k);
      coef_i      <= c;
    end
    @(posedge clk);
    coef_we_i <= 1'b0;
  endtask

  task automatic wait_idle();
    @(posedge clk);
    push_i <= 1'b0;
    while (due_q.size() > 0)
      @(posedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////
  task automatic idle_after_reset();
    repeat (IDLE_CYCLES)
    begin
      @(negedge clk);
      compare("valid_o", 64'(valid_o), 64'd0);
      compare("result_o.i", 64'(result_o.i), 64'd0);
      compare("result_o.q", 64'(result_o.q), 64'd0);
    end
  endtask

  task automatic impulse_response();
    cplx_sample_t s;
    int           k;
    load_coefs();
    for (int m = 0; m < NUM_TAPS; m++)
    begin
      s = '0;
      // 2^23 wraps to the most negative sample so outputs are negated taps
      if (m == 0)
        s.i = 24'h80_0000;
      push_sample(s, NUM_PHASES);
      k = (m < NUM_UNIQUE) ? m : NUM_TAPS - 1 - m;
      compare("expected tap i", 64'(last_exp.i), -(64'(coefs[k].i)));
      compare("expected tap q", 64'(last_exp.q), -(64'(coefs[k].q)));
    end
    wait_idle();
  endtask

  task automatic random_stream(input int n);
    repeat (n)
      push_sample(rand_sample(), NUM_PHASES);
    wait_idle();
  endtask

  // Pushes landing in PH_0 and PH_1 are dropped and the fourth lands in PH_2
  task automatic dropped_push();
    repeat (DROP_ROUNDS)
    begin
      push_sample(rand_sample(), 1);
      push_sample(rand_sample(), 1);
      push_sample(rand_sample(), 1);
      push_sample(rand_sample(), 3);
    end
    wait_idle();
  endtask

  task automatic coef_reload();
    wait_idle();
    load_coefs();
    random_stream(RELOAD_PUSHES);
  endtask

  task automatic irregular_spacing();
    repeat (IRREG_PUSHES)
      push_sample(rand_sample(), int'($urandom_range(6, 3)));
    wait_idle();
  endtask

  initial
  begin
    RST         = 1'b1;
    push_i      = 1'b0;
    sample_i    = '0;
    coef_we_i   = 1'b0;
    coef_addr_i = '0;
    coef_i      = '0;
    last_accept = -100;
    for (int t = 0; t < NUM_TAPS; t++)
      hist[t] = '0;
    for (int k = 0; k < NUM_UNIQUE; k++)
      coefs[k] = '0;
    void'($urandom(32'h26a1_f9b1));
    repeat (RESET_CYCLES) @(posedge clk);
    RST <= 1'b0;
    idle_after_reset();
    impulse_response();
    random_stream(RAND_PUSHES);
    dropped_push();
    coef_reload();
    irregular_spacing();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
